// File: filelist.f
+incdir+logic
logic/core_pkg.sv
logic/reg_port_if.sv
logic/core_ctrl.sv
logic/core_regs.sv
logic/core_alu.sv
logic/core_top.sv
tests/core_tb.sv

// File: logic/core_alu.sv
// core arithmetic logic unit
`timescale 1ns/1ns
`include "core_config.svh"

module core_alu(
    input                               clk,
    input                               rst,
    input                               cen,

    input        [`CORE_DATA_W-1:0]     a,          // dst register
    input        [`CORE_DATA_W-1:0]     b,          // src register
    input  core_pkg::opcode_e           alu_op,
    input                               flag_we,

    output logic [`CORE_DATA_W-1:0]     result,
    output logic                        zflag
);

// everything wraps at the word width
always_comb begin
    case (alu_op)
        core_pkg::OP_ADD: result = a + b;
        core_pkg::OP_SUB: result = a - b;
        core_pkg::OP_AND: result = a & b;
        core_pkg::OP_OR:  result = a | b;
        core_pkg::OP_XOR: result = a ^ b;
        default:          result = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        zflag <= 1'b0;
    end else if (cen && flag_we) begin
        zflag <= result == '0;
    end
end

// control must only raise flag_we for arithmetic and logic ops
a_flag_op: assert property (@(posedge clk) disable iff (rst)
    flag_we |-> alu_op inside {core_pkg::OP_ADD, core_pkg::OP_SUB,
                               core_pkg::OP_AND, core_pkg::OP_OR,
                               core_pkg::OP_XOR});

endmodule

// File: logic/core_config.svh
// core widths and sizes
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// register and RAM word width
`define CORE_DATA_W 16

// RAM word address width
`define CORE_ADDR_W 16

// register file size
`define CORE_NREGS  8
`define CORE_RSEL_W 3

// instruction word width
`define CORE_INSN_W 16

// immediate field width
`define CORE_IMM_W  8

`endif

// File: logic/core_ctrl.sv
// core control unit
`timescale 1ns/1ns
`include "core_config.svh"

module core_ctrl(
    input                               clk,
    input                               rst,
    input                               cen,

    output logic [`CORE_ADDR_W-1:0]     ram_addr,
    input        [`CORE_DATA_W-1:0]     ram_dout,
    output logic [`CORE_DATA_W-1:0]     ram_din,
    output logic                        ram_we,

    reg_port_if.ctrl                    rp,

    output core_pkg::opcode_e           alu_op,
    output logic                        flag_we,
    input        [`CORE_DATA_W-1:0]     alu_result,
    input                               zflag,

    output logic                        halted
);

core_pkg::state_e           state, next_state;
core_pkg::insn_u            insn;
logic [`CORE_ADDR_W-1:0]    pc;
logic [`CORE_ADDR_W-1:0]    jr_target;
logic                       in_exec, is_alu, is_mem, take_jump;

assign in_exec = state == core_pkg::EXEC;
assign is_alu  = insn.r.op inside {core_pkg::OP_ADD, core_pkg::OP_SUB,
                                   core_pkg::OP_AND, core_pkg::OP_OR,
                                   core_pkg::OP_XOR};
assign is_mem  = insn.r.op == core_pkg::OP_LD || insn.r.op == core_pkg::OP_ST;

// pc already points past the jump here
assign jr_target = pc + {{(`CORE_ADDR_W-`CORE_IMM_W){insn.i.imm[`CORE_IMM_W-1]}},
                         insn.i.imm};
assign take_jump = insn.r.op == core_pkg::OP_JR ||
                   (insn.r.op == core_pkg::OP_JRZ && zflag);

always_comb begin
    case (state)
        core_pkg::FETCH:  next_state = core_pkg::DECODE;
        core_pkg::DECODE: next_state = core_pkg::EXEC;
        core_pkg::EXEC: begin
            case (insn.r.op)
                core_pkg::OP_LD:   next_state = core_pkg::LOAD;
                core_pkg::OP_HALT: next_state = core_pkg::HALTED;
                default:           next_state = core_pkg::FETCH;
            endcase
        end
        core_pkg::LOAD:   next_state = core_pkg::FETCH;
        core_pkg::HALTED: next_state = core_pkg::HALTED;   // only rst leaves
        default:          next_state = core_pkg::FETCH;
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        state <= core_pkg::FETCH;
        pc    <= '0;
    end else if (cen) begin
        state <= next_state;
        if (state == core_pkg::DECODE) pc <= pc + 1'b1;
        if (in_exec && take_jump) pc <= jr_target;
    end
end

// instruction word arrives one cycle after fetch
always_ff @(posedge clk) begin
    if (cen && state == core_pkg::DECODE) insn <= ram_dout;
end

// memory side
assign ram_addr = (in_exec && is_mem) ? rp.src_data : pc;
assign ram_din  = rp.dst_data;
assign ram_we   = cen && in_exec && insn.r.op == core_pkg::OP_ST;

// register bank side
assign rp.src_sel = insn.r.src;
assign rp.dst_sel = insn.r.dst;
assign rp.we      = (in_exec && (is_alu || insn.i.op == core_pkg::OP_LDI)) ||
                    state == core_pkg::LOAD;

always_comb begin
    if (state == core_pkg::LOAD)
        rp.wdata = ram_dout;
    else if (insn.i.op == core_pkg::OP_LDI)
        rp.wdata = {{(`CORE_DATA_W-`CORE_IMM_W){1'b0}}, insn.i.imm};  // zero extended
    else
        rp.wdata = alu_result;
end

assign alu_op  = insn.r.op;
assign flag_we = in_exec && is_alu;   // ldi leaves zflag alone
assign halted  = state == core_pkg::HALTED;

// a store writes once, then the next fetch starts
a_we_store: assert property (@(posedge clk) disable iff (rst)
    ram_we |=> state == core_pkg::FETCH);

// halt is sticky until reset
a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halted |=> halted);

endmodule

// File: logic/core_pkg.sv
// core shared types
`include "core_config.svh"

package core_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LDI  = 4'd1,
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_AND  = 4'd4,
        OP_OR   = 4'd5,
        OP_XOR  = 4'd6,
        OP_LD   = 4'd7,
        OP_ST   = 4'd8,
        OP_JR   = 4'd9,
        OP_JRZ  = 4'd10,
        OP_HALT = 4'd15     // 11..14 behave as nop
    } opcode_e;

    // register form: op dst src
    typedef struct packed {
        opcode_e                 op;
        logic [`CORE_RSEL_W-1:0] dst;
        logic [`CORE_RSEL_W-1:0] src;
        logic [5:0]              rsvd;
    } insn_reg_t;

    // immediate form: op dst imm
    typedef struct packed {
        opcode_e                 op;
        logic [`CORE_RSEL_W-1:0] dst;
        logic                    rsvd;
        logic [`CORE_IMM_W-1:0]  imm;
    } insn_imm_t;

    typedef union packed {
        insn_reg_t r;
        insn_imm_t i;
    } insn_u;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXEC,
        LOAD,
        HALTED
    } state_e;

endpackage

// File: logic/core_regs.sv
// core register bank
`timescale 1ns/1ns
`include "core_config.svh"

module core_regs(
    input                               clk,
    input                               rst,
    input                               cen,

    reg_port_if.regs                    rp,

    // register dump
    input        [`CORE_RSEL_W-1:0]     dmp_addr,
    output logic [`CORE_DATA_W-1:0]     dmp_din
);

logic [`CORE_DATA_W-1:0] regs [`CORE_NREGS];

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < `CORE_NREGS; i++) begin
            regs[i] <= '0;
        end
    end else if (cen && rp.we) begin
        regs[rp.dst_sel] <= rp.wdata;
    end
end

// combinational read ports
assign rp.src_data = regs[rp.src_sel];
assign rp.dst_data = regs[rp.dst_sel];     // also the alu a operand
assign dmp_din     = regs[dmp_addr];

// decoded select from control must be clean on writes
a_wsel_known: assert property (@(posedge clk) disable iff (rst)
    rp.we |-> !$isunknown(rp.dst_sel));

endmodule

// File: logic/core_top.sv
// 16-bit core top level
`timescale 1ns/1ns
`include "core_config.svh"

module core_top(
    input                           clk,
    input                           rst,
    input                           cen,

    output [`CORE_ADDR_W-1:0]       ram_addr,
    input  [`CORE_DATA_W-1:0]       ram_dout,
    output [`CORE_DATA_W-1:0]       ram_din,
    output                          ram_we,
    // register dump
    input  [`CORE_RSEL_W-1:0]       dmp_addr,
    output [`CORE_DATA_W-1:0]       dmp_din,

    output                          halted
);

core_pkg::opcode_e          alu_op;
logic                       flag_we, zflag;
logic [`CORE_DATA_W-1:0]    alu_result;

reg_port_if u_rp();

core_ctrl u_ctrl(
    .clk            ( clk               ),
    .rst            ( rst               ),
    .cen            ( cen               ),
    .ram_addr       ( ram_addr          ),
    .ram_dout       ( ram_dout          ),
    .ram_din        ( ram_din           ),
    .ram_we         ( ram_we            ),
    .rp             ( u_rp.ctrl         ),
    .alu_op         ( alu_op            ),
    .flag_we        ( flag_we           ),
    .alu_result     ( alu_result        ),
    .zflag          ( zflag             ),
    .halted         ( halted            )
);

core_regs u_regs(
    .clk            ( clk               ),
    .rst            ( rst               ),
    .cen            ( cen               ),
    .rp             ( u_rp.regs         ),
    .dmp_addr       ( dmp_addr          ),
    .dmp_din        ( dmp_din           )
);

core_alu u_alu(
    .clk            ( clk               ),
    .rst            ( rst               ),
    .cen            ( cen               ),
    .a              ( u_rp.dst_data     ),
    .b              ( u_rp.src_data     ),
    .alu_op         ( alu_op            ),
    .flag_we        ( flag_we           ),
    .result         ( alu_result        ),
    .zflag          ( zflag             )
);

endmodule

// File: logic/reg_port_if.sv
// control to register bank port
`timescale 1ns/1ns
`include "core_config.svh"

interface reg_port_if;

    logic [`CORE_RSEL_W-1:0] src_sel;
    logic [`CORE_RSEL_W-1:0] dst_sel;
    logic                    we;        // qualified by cen in the bank
    logic [`CORE_DATA_W-1:0] wdata;
    logic [`CORE_DATA_W-1:0] src_data;
    logic [`CORE_DATA_W-1:0] dst_data;

    modport ctrl (
        output src_sel, dst_sel, we, wdata,
        input  src_data, dst_data
    );

    modport regs (
        input  src_sel, dst_sel, we, wdata,
        output src_data, dst_data
    );

endinterface

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module core_tb \
    -f filelist.f -o core_sim \
    && ./obj_dir/core_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test completed successfully" sim.log && echo PASS || { echo FAIL; exit 1; }

// File: tests/core_tb.sv
// core testbench
`timescale 1ns/1ns
`include "core_config.svh"

module core_tb;

logic                       clk;
logic                       rst;
logic                       cen = 1'b1;            // moves 1 ns after each edge
logic [`CORE_ADDR_W-1:0]    ram_addr;
logic [`CORE_DATA_W-1:0]    ram_dout = '0;
logic [`CORE_DATA_W-1:0]    ram_din;
logic                       ram_we;
logic [`CORE_RSEL_W-1:0]    dmp_addr;
logic [`CORE_DATA_W-1:0]    dmp_din;
logic                       halted;

logic [`CORE_DATA_W-1:0]    ram [256];
logic [`CORE_DATA_W-1:0]    init_mem [256];
logic [`CORE_DATA_W-1:0]    exp_mem [256];
logic [`CORE_DATA_W-1:0]    exp_regs [`CORE_NREGS];
logic [31:0]                rng = 32'h59d2_2d01;
logic [31:0]                cen_rng = 32'h59d2_2d01;
logic                       cen_random = 1'b0;
logic                       reload = 1'b0;     // copies init_mem into the RAM
int                         prog_len = 0;
int                         loop_n = 0;

core_top dut_i(.*);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

// word RAM with one cycle of read latency
always @(posedge clk) begin
    if (reload) begin
        for (int i = 0; i < 256; i++) ram[i] <= init_mem[i];
    end else if (cen) begin
        if (ram_we) ram[ram_addr[7:0]] <= ram_din;
        ram_dout <= ram[ram_addr[7:0]];
    end
end

always @(posedge clk) begin
    #1;
    cen_rng = xorshift(cen_rng);
    cen = !cen_random || cen_rng[1:0] != 2'b00;    // low about one cycle in four
end

always @(posedge clk) begin
    if (!rst) check_equal(16'(ram_we & ~cen), 16'h0000, "ram_we while cen low");
end

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
endfunction

function automatic void emit(input logic [3:0] op, input logic [2:0] d, input logic [8:0] low);
    init_mem[prog_len] = {op, d, low};
    prog_len++;
endfunction

task automatic stop_failed();
    $display("Test failed");
    $fatal(1, "stopped at the first error");
endtask

task automatic check_equal(input logic [`CORE_DATA_W-1:0] got,
                           input logic [`CORE_DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
        $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        stop_failed();
    end
endtask

// random alu mix, stores and loads, then a countdown loop
task automatic build_program();
    logic [31:0] r;
    logic [7:0]  st_addr [8];
    for (int a = 0; a < 256; a++) init_mem[a] = 16'(a * 40503) ^ 16'(a << 7) ^ 16'h3c5a;
    for (int i = 0; i < `CORE_NREGS; i++) begin
        r = next_rand();
        emit(core_pkg::OP_LDI, 3'(i), {1'b0, r[7:0]});
    end
    emit(core_pkg::OP_LDI, 3'd0, 9'h0c3);
    repeat (9) emit(core_pkg::OP_ADD, 3'd0, {3'd0, 6'd0});   // doubles past 16 bits
    for (int i = 0; i < 30; i++) begin
        r = next_rand();
        if (r[2:1] == 2'b00)
            emit(core_pkg::OP_LDI, r[5:3], {1'b0, r[16:9]});
        else if (r[2:0] == 3'd7)
            emit(core_pkg::OP_SUB, r[5:3], {r[8:6], 6'd0});
        else
            emit({1'b0, r[2:0]}, r[5:3], {r[8:6], 6'd0});      // add through xor
    end
    for (int i = 0; i < 8; i++) begin
        r = next_rand();
        st_addr[i] = {1'b1, r[12:6]};                          // data region 0x80 and up
        emit(core_pkg::OP_LDI, r[2:0], {1'b0, st_addr[i]});
        emit(core_pkg::OP_ST, r[5:3], {r[2:0], 6'd0});
    end
    for (int i = 0; i < 8; i++) begin
        r = next_rand();
        emit(core_pkg::OP_LDI, r[2:0], {1'b0, (r[13] ? st_addr[r[16:14]] : {1'b1, r[12:6]})});
        emit(core_pkg::OP_LD, r[5:3], {r[2:0], 6'd0});
    end
    r = next_rand();
    loop_n = 2 + int'(r[3:0]);
    emit(core_pkg::OP_LDI, 3'd1, {1'b0, 8'(loop_n)});
    emit(core_pkg::OP_LDI, 3'd2, 9'h001);
    emit(core_pkg::OP_LDI, 3'd3, 9'h000);
    emit(core_pkg::OP_ADD, 3'd3, {3'd2, 6'd0});    // loop top, counts iterations
    emit(core_pkg::OP_SUB, 3'd1, {3'd2, 6'd0});
    emit(core_pkg::OP_LDI, 3'd5, 9'h000);          // zero result, flag must stay
    emit(core_pkg::OP_JRZ, 3'd0, 9'h001);          // skips the backward jump
    emit(core_pkg::OP_JR, 3'd0, 9'h0fb);           // -5, back to the add
    emit(core_pkg::OP_HALT, 3'd0, 9'h000);
endtask

// instruction set interpreter, returns the number of executed instructions
function automatic int run_reference();
    logic [15:0] pc;
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] simm;
    logic        z;
    logic        done;
    int          n;
    for (int i = 0; i < 256; i++) exp_mem[i] = init_mem[i];
    for (int i = 0; i < `CORE_NREGS; i++) exp_regs[i] = '0;
    pc = '0;
    z = 1'b0;
    done = 1'b0;
    n = 0;
    while (!done && n < 10000) begin
        w = exp_mem[pc[7:0]];
        a = exp_regs[w[11:9]];
        b = exp_regs[w[8:6]];
        simm = {{8{w[7]}}, w[7:0]};
        pc = pc + 16'd1;
        n++;
        case (w[15:12])
            core_pkg::OP_LDI:  exp_regs[w[11:9]] = {8'h00, w[7:0]};
            core_pkg::OP_ADD:  a = a + b;
            core_pkg::OP_SUB:  a = a - b;
            core_pkg::OP_AND:  a = a & b;
            core_pkg::OP_OR:   a = a | b;
            core_pkg::OP_XOR:  a = a ^ b;
            core_pkg::OP_LD:   exp_regs[w[11:9]] = exp_mem[b[7:0]];
            core_pkg::OP_ST:   exp_mem[b[7:0]] = a;
            core_pkg::OP_JR:   pc = pc + simm;
            core_pkg::OP_JRZ:  if (z) pc = pc + simm;
            core_pkg::OP_HALT: done = 1'b1;
            default: ;
        endcase
        if (w[15:12] >= 4'd2 && w[15:12] <= 4'd6) begin   // add through xor
            exp_regs[w[11:9]] = a;
            z = a == 16'd0;
        end
    end
    return n;
endfunction

// one run from reset to halt, compared with the reference
task automatic run_program(input logic random_cen, input int n_exec);
    int cycles;
    int limit;
    limit = n_exec * 4 * 2 + 100;
    @(posedge clk);
    #1;
    rst = 1'b1;
    reload = 1'b1;
    cen_random = random_cen;
    @(posedge clk);
    #1;
    reload = 1'b0;
    @(posedge clk);
    #1;
    rst = 1'b0;
    #1;
    check_equal(16'(halted), 16'h0000, "halted after reset");
    check_equal(16'(ram_we), 16'h0000, "ram_we after reset");
    check_equal(ram_addr, 16'h0000, "first fetch address");
    cycles = 0;
    while (!halted) begin
        @(posedge clk);
        #2;
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the core did not halt within %0d cycles", limit);
            stop_failed();
        end
    end
    repeat (20) begin
        @(posedge clk);
        #2;
        check_equal(16'(halted), 16'h0001, "halted after halt");
        check_equal(16'(ram_we), 16'h0000, "ram_we after halt");
    end
    for (int i = 0; i < `CORE_NREGS; i++) begin
        @(posedge clk);
        #1;
        dmp_addr = 3'(i);
        #1;
        check_equal(dmp_din, exp_regs[i], $sformatf("register r%0d", i));
        if (i == 3) check_equal(dmp_din, 16'(loop_n), "loop iteration count");
    end
    for (int a = 0; a < 256; a++) check_equal(ram[a], exp_mem[a], $sformatf("RAM word %0d", a));
endtask

initial begin
    int n_exec;
    rst = 1'b1;
    dmp_addr = '0;
    build_program();
    n_exec = run_reference();
    $display("program of %0d words, %0d instructions, loop count %0d", prog_len, n_exec, loop_n);
    run_program(1'b0, n_exec);     // cen always high
    run_program(1'b1, n_exec);     // cen low on random cycles
    $display("Test completed successfully");
    $finish;
end

endmodule
